// ==== compile.f ====
design/ucode_pkg.sv
design/opq_if.sv
design/apb_op_port.sv
design/op_queue.sv
design/ucode_seq.sv
design/ucode_top.sv
bench/tb_ucode_top.sv

// ==== Makefile ====
VERILATOR ?= verilator
FLAGS     ?= --timing
TOP       ?= tb_ucode_top
RTL_TOP   ?= ucode_top
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Simulation PASSED

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)
	$(VERILATOR) --lint-only $(FLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(FLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== bench/tb_ucode_top.sv ====
// testbench for the microcode sequencer top level
// opcode table runs, APB tasks, pulse monitor, random hold and watchdog
`timescale 1ns/1ns
`default_nettype none

module tb_ucode_top;
    import ucode_pkg::*;

    typedef struct packed {
        logic [OP_W-1:0]  op;
        logic [CAT_W-1:0] cat;
        logic [3:0]       steps;  // control steps of the routine
    } row_t;

    localparam int NROWS = 8;
    localparam row_t ROWS [NROWS] = '{
        '{OP_NOP,  CAT_NOP,    4'd1},
        '{OP_ADDA, CAT_ALU8,   4'd2},
        '{OP_LDA,  CAT_ALU8,   4'd2},
        '{OP_ADDD, CAT_ALU16,  4'd3},
        '{OP_LDX,  CAT_ALU16,  4'd3},
        '{OP_BRA,  CAT_BRANCH, 4'd2},
        '{OP_BNE,  CAT_BRANCH, 4'd2},
        '{OP_PSHS, CAT_PUSH,   4'd4}
    };

    logic             clk = 1'b0;
    logic             rst;
    logic             psel;
    logic             penable;
    logic             pwrite;
    logic [3:0]       paddr;
    logic [31:0]      pwdata;
    logic [31:0]      prdata;
    logic             pready;
    logic             pslverr;
    logic             irq;
    logic             hold = 1'b0;
    logic             ctl_valid;
    logic [14:0]      ctl_word;
    logic [CAT_W-1:0] ctl_cat;
    logic             intvec;
    logic             busy;

    int               errors = 0;
    int               checks = 0;
    int               cyc = 0;
    int               phase_start = 0;
    int               limit = 1000;
    int               total;
    integer           seed;
    logic             rand_hold = 1'b0;
    logic             hold_level = 1'b0;
    logic             in_routine = 1'b0;
    logic [STEP_W-1:0] step_idx = '0;  // step within the running routine
    int               pulses [16];
    int               all_pulses;
    int               vec_pulses;
    int               first_cyc;
    int               wr_cyc;
    logic [CAT_W-1:0] order [$];  // category of each routine, in run order
    logic             err;
    logic [31:0]      rd;

    ucode_top DUT (
        .clk(clk), .rst(rst), .psel(psel), .penable(penable), .pwrite(pwrite),
        .paddr(paddr), .pwdata(pwdata), .prdata(prdata), .pready(pready),
        .pslverr(pslverr), .irq(irq), .hold(hold), .ctl_valid(ctl_valid),
        .ctl_word(ctl_word), .ctl_cat(ctl_cat), .intvec(intvec), .busy(busy)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        if (rand_hold) begin
            hold <= ($random(seed) % 2) != 0;
        end else begin
            hold <= hold_level;
        end
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED %s: got 0x%h, expected 0x%h (cycle %0d)", name, got, exp, cyc);
        end
    endtask

    // pulse monitor and watchdog
    always @(posedge clk) begin
        cyc <= cyc + 1;
        if (cyc - phase_start > limit) begin
            $display("timeout: test phase ran past %0d cycles", limit);
            $display("Simulation FAILED");
            $finish;
        end else if (ctl_valid) begin
            if (!in_routine) begin
                order.push_back(ctl_cat);
                first_cyc = cyc;
                step_idx = '0;
            end
            in_routine = 1'b1;
            // each step shows up once, in ROM order
            check_value("ctl_word", 32'(ctl_word),
                        32'(UCODE_ROM[{ctl_cat, step_idx}].ctl.strobes));
            step_idx++;
            pulses[ctl_cat]++;
            all_pulses++;
            if (intvec) vec_pulses++;
            check_value("busy", 32'(busy), 1);
            check_value("intvec", 32'(intvec), 32'(ctl_cat == CAT_IRQ));
        end else if (!hold) begin
            in_routine = 1'b0;  // END word or idle
        end
    end

    task automatic start_phase();
        phase_start = cyc;
        for (int c = 0; c < 16; c++) pulses[c] = 0;
        all_pulses = 0;
        vec_pulses = 0;
        order.delete();
    endtask

    task automatic apb_write(input logic [3:0] addr, input logic [31:0] data,
                             output logic slverr);
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= 1'b1;
        paddr   <= addr;
        pwdata  <= data;
        @(posedge clk);
        penable <= 1'b1;
        @(posedge clk);  // access phase ends, no wait states
        check_value("pready", 32'(pready), 1);
        slverr = pslverr;
        wr_cyc = cyc;
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic apb_read(input logic [3:0] addr, output logic [31:0] data);
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= 1'b0;
        paddr   <= addr;
        @(posedge clk);
        penable <= 1'b1;
        @(posedge clk);
        data = prdata;
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    // idle with hold low means the queue is drained too
    task automatic wait_idle();
        int quiet;
        quiet = 0;
        while (quiet < 3) begin
            @(posedge clk);
            if (busy) quiet = 0;
            else if (!hold) quiet++;
        end
    endtask

    task automatic check_burst();
        int exp_cat [16];
        int sum;
        sum = 0;
        for (int c = 0; c < 16; c++) exp_cat[c] = 0;
        for (int i = 0; i < NROWS; i++) begin
            exp_cat[ROWS[i].cat] += 32'(ROWS[i].steps);
            sum += 32'(ROWS[i].steps);
        end
        check_value("total pulses", all_pulses, sum);
        for (int c = 0; c < 16; c++) check_value("pulses per category", pulses[c], exp_cat[c]);
        check_value("routine count", order.size(), NROWS);
        for (int i = 0; i < NROWS && i < order.size(); i++) begin
            check_value("routine order", 32'(order[i]), 32'(ROWS[i].cat));
        end
    endtask

    initial begin
        seed = 32'hb055_6a17;
        rst = 1'b1;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        paddr = 4'h0;
        pwdata = 32'd0;
        irq = 1'b0;
        total = 0;
        for (int i = 0; i < NROWS; i++) total += 32'(ROWS[i].steps) + 1;
        limit = 4 * total + 200;  // per test phase
        repeat (3) @(posedge clk);
        rst <= 1'b0;

        // each opcode alone
        for (int i = 0; i < NROWS; i++) begin
            start_phase();
            apb_write(REG_OPCODE, {24'd0, ROWS[i].op}, err);
            check_value("pslverr", 32'(err), 0);
            wait_idle();
            check_value("pulses", all_pulses, 32'(ROWS[i].steps));
            check_value("pulses in category", pulses[ROWS[i].cat], 32'(ROWS[i].steps));
            check_value("routine count", order.size(), 1);
            check_value("push to first pulse", first_cyc - wr_cyc, 2);
        end

        // burst, then again under random hold
        for (int pass = 0; pass < 2; pass++) begin
            start_phase();
            rand_hold <= (pass == 1);
            for (int i = 0; i < NROWS; i++) begin
                apb_write(REG_OPCODE, {24'd0, ROWS[i].op}, err);
                check_value("pslverr", 32'(err), 0);
            end
            wait_idle();
            rand_hold <= 1'b0;
            check_burst();
            apb_read(REG_STATUS, rd);
            check_value("status count", 32'(rd[3:0]), 0);
        end

        // interrupt taken before the queued opcode
        start_phase();
        apb_write(REG_CTRL, 32'h1, err);
        hold_level <= 1'b1;
        apb_write(REG_OPCODE, {24'd0, OP_LDA}, err);
        irq <= 1'b1;
        hold_level <= 1'b0;
        while (!intvec) @(posedge clk);
        irq <= 1'b0;
        wait_idle();
        check_value("routine count", order.size(), 2);
        check_value("first routine", 32'(order[0]), 32'(CAT_IRQ));
        check_value("second routine", 32'(order[1]), 32'(CAT_ALU8));
        check_value("irq pulses", pulses[CAT_IRQ], 3);
        check_value("intvec pulses", vec_pulses, 3);
        check_value("alu8 pulses", pulses[CAT_ALU8], 2);

        // irq ignored with int_en clear
        start_phase();
        apb_write(REG_CTRL, 32'h0, err);
        irq <= 1'b1;
        apb_write(REG_OPCODE, {24'd0, OP_BRA}, err);
        wait_idle();
        irq <= 1'b0;
        check_value("routine count", order.size(), 1);
        check_value("branch pulses", pulses[CAT_BRANCH], 2);
        check_value("irq pulses", pulses[CAT_IRQ], 0);

        // unknown opcode, sticky error and its clear
        start_phase();
        apb_write(REG_OPCODE, 32'h0000_00ff, err);
        wait_idle();
        check_value("pulses", all_pulses, 1);
        check_value("buserr pulses", pulses[CAT_BUSERR], 1);
        apb_read(REG_STATUS, rd);
        check_value("status err", 32'(rd[5]), 1);
        apb_write(REG_CTRL, 32'h2, err);
        apb_read(REG_STATUS, rd);
        check_value("status err", 32'(rd[5]), 0);

        // overfill a held queue
        start_phase();
        hold_level <= 1'b1;
        for (int i = 0; i < 9; i++) begin
            apb_write(REG_OPCODE, {24'd0, OP_NOP}, err);
            check_value("pslverr", 32'(err), 32'(i == 8));
        end
        apb_read(REG_STATUS, rd);
        check_value("status count", 32'(rd[3:0]), 8);
        hold_level <= 1'b0;
        wait_idle();
        check_value("nop pulses", pulses[CAT_NOP], 8);

        $display("run complete: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== design/ucode_top.sv ====
// sequencer top level: APB opcode port, opcode queue, microcode sequencer
`timescale 1ns/1ns
`default_nettype none

module ucode_top (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        psel,
    input  logic                        penable,
    input  logic                        pwrite,
    input  logic [3:0]                  paddr,
    input  logic [31:0]                 pwdata,
    output logic [31:0]                 prdata,
    output logic                        pready,
    output logic                        pslverr,
    input  logic                        irq,
    input  logic                        hold,
    output logic                        ctl_valid,
    output logic [14:0]                 ctl_word,
    output logic [ucode_pkg::CAT_W-1:0] ctl_cat,
    output logic                        intvec,
    output logic                        busy
);

    logic int_en;
    logic err_set;

    opq_if opq ();

    apb_op_port u_port (
        .clk     (clk),
        .rst     (rst),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr),
        .q       (opq.producer),
        .busy    (busy),
        .err_set (err_set),
        .int_en  (int_en)
    );

    op_queue u_queue (
        .clk (clk),
        .rst (rst),
        .p   (opq.queue)
    );

    ucode_seq u_seq (
        .clk       (clk),
        .rst       (rst),
        .hold      (hold),
        .irq       (irq),
        .int_en    (int_en),
        .q         (opq.consumer),
        .ctl_valid (ctl_valid),
        .ctl_word  (ctl_word),
        .ctl_cat   (ctl_cat),
        .intvec    (intvec),
        .busy      (busy),
        .err_set   (err_set)
    );

endmodule

`default_nettype wire

// ==== design/ucode_seq.sv ====
// microcode sequencer: opcode decode, microcode address counter,
// interrupt entry at instruction boundaries and control word output
`timescale 1ns/1ns
`default_nettype none

module ucode_seq (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       hold,
    input  logic                       irq,
    input  logic                       int_en,
    opq_if.consumer                    q,
    output logic                       ctl_valid,
    output logic [14:0]                ctl_word,
    output logic [ucode_pkg::CAT_W-1:0] ctl_cat,
    output logic                       intvec,
    output logic                       busy,
    output logic                       err_set
);
    import ucode_pkg::*;

    logic [UADDR_W-1:0] uaddr;     // {category, step}
    logic               running;
    ucode_word_u        uword;
    logic [CAT_W-1:0]   op_cat;
    logic               is_ctl;
    logic               is_jmp;
    logic               is_loop;
    logic               is_end;
    logic               boundary;
    logic               take_irq;
    logic               do_pop;

    // opcode to routine category
    always_comb begin
        case (q.head_op)
            OP_NOP:          op_cat = CAT_NOP;
            OP_ADDA, OP_LDA: op_cat = CAT_ALU8;
            OP_ADDD, OP_LDX: op_cat = CAT_ALU16;
            OP_BRA, OP_BNE:  op_cat = CAT_BRANCH;
            OP_PSHS:         op_cat = CAT_PUSH;
            default:         op_cat = CAT_BUSERR; // unknown opcode
        endcase
    end

    assign uword = UCODE_ROM[uaddr];

    assign is_ctl  = running && !uword.ctl.kind;
    assign is_jmp  = running && uword.jmp.kind;
    assign is_loop = is_jmp && (uword.jmp.cond == JC_LOOP);
    // any other jump condition ends the routine
    assign is_end  = is_jmp && !is_loop;

    // fetch point, idle or the END word of a routine
    assign boundary = !running || is_end;

    // intvec still set means the irq routine is just ending,
    // so one opcode gets a turn before the next entry
    assign take_irq = boundary && irq && int_en && !intvec && !hold;
    assign do_pop   = boundary && !q.empty && !take_irq && !hold;
    assign q.pop    = do_pop;

    // hold freezes the step, shown again once hold drops
    assign ctl_valid = is_ctl && !hold;
    assign ctl_word  = ctl_valid ? uword.ctl.strobes : 15'd0;
    assign ctl_cat   = uaddr[UADDR_W-1 -: CAT_W];
    assign busy      = running;

    always_ff @(posedge clk) begin
        if (rst) begin
            uaddr   <= '0;
            running <= 1'b0;
            intvec  <= 1'b0;
            err_set <= 1'b0;
        end else begin
            err_set <= 1'b0;                  // single pulse
            if (!hold) begin
                if (take_irq) begin
                    uaddr   <= {CAT_IRQ, {STEP_W{1'b0}}};
                    running <= 1'b1;
                    intvec  <= 1'b1;
                end else if (do_pop) begin
                    uaddr   <= {op_cat, {STEP_W{1'b0}}};
                    running <= 1'b1;
                    intvec  <= 1'b0;
                    err_set <= (op_cat == CAT_BUSERR);
                end else if (is_end) begin
                    running <= 1'b0;          // queue empty, go idle
                    intvec  <= 1'b0;
                end else if (is_loop) begin
                    uaddr <= {uword.jmp.target, {STEP_W{1'b0}}};
                end else if (is_ctl) begin
                    uaddr <= uaddr + 1'b1;    // next step
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== design/op_queue.sv ====
// opcode FIFO, circular buffer with fill count
`timescale 1ns/1ns
`default_nettype none

module op_queue (
    input  logic clk,
    input  logic rst,
    opq_if.queue p
);
    import ucode_pkg::*;

    logic [OP_W-1:0]           mem [QDEPTH];
    logic [$clog2(QDEPTH)-1:0] wr_ptr;
    logic [$clog2(QDEPTH)-1:0] rd_ptr;
    logic [QCNT_W-1:0]         count;
    logic                      do_push;
    logic                      do_pop;

    assign do_push = p.push && !p.full;
    assign do_pop  = p.pop && !p.empty;

    assign p.full    = (count == QCNT_W'(QDEPTH));
    assign p.empty   = (count == '0);
    assign p.count   = count;
    assign p.head_op = mem[rd_ptr];   // oldest entry

    // storage, no reset needed
    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= p.push_op;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;  // wraps at depth
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;  // both or neither
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== design/apb_op_port.sv ====
// APB slave with opcode, status and control registers
// written opcodes go straight into the queue
`timescale 1ns/1ns
`default_nettype none

module apb_op_port (
    input  logic        clk,
    input  logic        rst,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [3:0]  paddr,
    input  logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic        pready,
    output logic        pslverr,
    opq_if.producer     q,
    input  logic        busy,
    input  logic        err_set,
    output logic        int_en
);
    import ucode_pkg::*;

    logic access;
    logic addr_ok;
    logic op_wr;
    logic ctrl_wr;
    logic err_flag;  // sticky bus error

    assign access  = psel && penable;
    assign addr_ok = paddr inside {REG_OPCODE, REG_STATUS, REG_CTRL};
    assign op_wr   = access && pwrite && (paddr == REG_OPCODE);
    assign ctrl_wr = access && pwrite && (paddr == REG_CTRL);

    // push lands in the access phase itself
    assign q.push    = op_wr && !q.full;
    assign q.push_op = pwdata[OP_W-1:0];

    assign pready  = 1'b1;               // no wait states
    assign pslverr = access && (!addr_ok || (op_wr && q.full)); // full write drops the opcode

    always_comb begin
        case (paddr)
            REG_STATUS: prdata = {26'd0, err_flag, busy, q.count};
            REG_CTRL:   prdata = {31'd0, int_en};
            default:    prdata = 32'd0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            int_en   <= 1'b0;
            err_flag <= 1'b0;
        end else begin
            if (ctrl_wr) begin
                int_en <= pwdata[0];
            end
            if (err_set) begin
                err_flag <= 1'b1;        // new fault beats a clear
            end else if (ctrl_wr && pwdata[1]) begin
                err_flag <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// ==== design/opq_if.sv ====
// opcode queue interface, producer, queue and consumer modports
`timescale 1ns/1ns
`default_nettype none

interface opq_if;
    import ucode_pkg::*;

    logic              push;
    logic [OP_W-1:0]   push_op;
    logic              full;
    logic              pop;    // takes head_op in the same cycle
    logic [OP_W-1:0]   head_op;
    logic              empty;
    logic [QCNT_W-1:0] count;

    modport producer (output push, push_op, input full, count);
    modport queue    (input push, push_op, pop, output full, head_op, empty, count);
    modport consumer (output pop, input head_op, empty);

endinterface

`default_nettype wire

// ==== design/ucode_pkg.sv ====
// shared widths, opcode and category codes for the microcode sequencer
// microcode word union and the microcode ROM table
package ucode_pkg;

    localparam int OP_W    = 8;
    localparam int CAT_W   = 4;
    localparam int UADDR_W = 7;               // category, then step
    localparam int STEP_W  = UADDR_W - CAT_W;
    localparam int QDEPTH  = 8;
    localparam int QCNT_W  = 4;

    localparam logic [CAT_W-1:0] CAT_NOP    = 4'd0;
    localparam logic [CAT_W-1:0] CAT_ALU8   = 4'd1;
    localparam logic [CAT_W-1:0] CAT_ALU16  = 4'd2;
    localparam logic [CAT_W-1:0] CAT_BRANCH = 4'd3;
    localparam logic [CAT_W-1:0] CAT_PUSH   = 4'd4;
    localparam logic [CAT_W-1:0] CAT_IRQ    = 4'd14;
    localparam logic [CAT_W-1:0] CAT_BUSERR = 4'd15;

    localparam logic [OP_W-1:0] OP_NOP  = 8'h12; // nop
    localparam logic [OP_W-1:0] OP_ADDA = 8'h8b; // alu8
    localparam logic [OP_W-1:0] OP_LDA  = 8'h86; // alu8
    localparam logic [OP_W-1:0] OP_ADDD = 8'hc3; // alu16
    localparam logic [OP_W-1:0] OP_LDX  = 8'h8e; // alu16
    localparam logic [OP_W-1:0] OP_BRA  = 8'h20; // branch
    localparam logic [OP_W-1:0] OP_BNE  = 8'h26; // branch
    localparam logic [OP_W-1:0] OP_PSHS = 8'h34; // push

    localparam logic [2:0] JC_END  = 3'd0;  // back to fetch
    localparam logic [2:0] JC_LOOP = 3'd1;  // restart at step 0

    localparam logic [3:0] REG_OPCODE = 4'h0;
    localparam logic [3:0] REG_STATUS = 4'h4;
    localparam logic [3:0] REG_CTRL   = 4'h8;

    // one microcode word, kind bit selects the view
    typedef union packed {
        struct packed {
            logic        kind;    // 0
            logic [14:0] strobes;
        } ctl;
        struct packed {
            logic             kind;   // 1
            logic [2:0]       cond;
            logic [7:0]       rsvd;
            logic [CAT_W-1:0] target;
        } jmp;
    } ucode_word_u;

    function automatic ucode_word_u mk_ctl(input logic [14:0] strobes);
        ucode_word_u w;
        w = '0;
        w.ctl.strobes = strobes;
        return w;
    endfunction

    function automatic ucode_word_u mk_end(input logic [CAT_W-1:0] cat);
        ucode_word_u w;
        w = '0;
        w.jmp.kind   = 1'b1;
        w.jmp.cond   = JC_END;
        w.jmp.target = cat;
        return w;
    endfunction

    function automatic ucode_word_u [0:2**UADDR_W-1] rom_init();
        ucode_word_u [0:2**UADDR_W-1] rom;
        for (int i = 0; i < 2**UADDR_W; i++) begin
            rom[i] = mk_end(i[UADDR_W-1:STEP_W]); // every unwritten step ends
        end
        rom[{CAT_NOP, 3'd0}]    = mk_ctl(15'h0001); // pc advance only
        rom[{CAT_ALU8, 3'd0}]   = mk_ctl(15'h0003); // operand fetch
        rom[{CAT_ALU8, 3'd1}]   = mk_ctl(15'h0110); // alu, write acc
        rom[{CAT_ALU16, 3'd0}]  = mk_ctl(15'h0003);
        rom[{CAT_ALU16, 3'd1}]  = mk_ctl(15'h0005); // low byte
        rom[{CAT_ALU16, 3'd2}]  = mk_ctl(15'h0230);
        rom[{CAT_BRANCH, 3'd0}] = mk_ctl(15'h0003); // offset fetch
        rom[{CAT_BRANCH, 3'd1}] = mk_ctl(15'h0800); // load pc if taken
        rom[{CAT_PUSH, 3'd0}]   = mk_ctl(15'h1040); // dec sp
        rom[{CAT_PUSH, 3'd1}]   = mk_ctl(15'h1082); // write low
        rom[{CAT_PUSH, 3'd2}]   = mk_ctl(15'h1040);
        rom[{CAT_PUSH, 3'd3}]   = mk_ctl(15'h1082); // write high
        rom[{CAT_IRQ, 3'd0}]    = mk_ctl(15'h2040); // stack pc
        rom[{CAT_IRQ, 3'd1}]    = mk_ctl(15'h2082);
        rom[{CAT_IRQ, 3'd2}]    = mk_ctl(15'h4008); // vector into pc
        rom[{CAT_BUSERR, 3'd0}] = mk_ctl(15'h4000); // flag fault
        return rom;
    endfunction

    localparam ucode_word_u [0:2**UADDR_W-1] UCODE_ROM = rom_init();

endpackage
